// File: rv_core.f
+incdir+sim
hdl/rv_pkg.sv
hdl/rv_fetch.sv
hdl/rv_decode.sv
hdl/rv_regfile.sv
hdl/rv_execute.sv
hdl/rv_core.sv
sim/rv_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module rv_core_tb -Mdir obj_dir -f rv_core.f

output=$(./obj_dir/Vrv_core_tb 2>&1 || true)
echo "$output"

if grep -qF "TEST RESULT: PASS" <<< "$output"; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: sim/rv_model.svh
// model state, cleared by the testbench before the run
word_t xreg [NUM_REGS];
word_t dmem_model [DMEM_WORDS];
word_t model_pc;
logic  exp_we;
word_t exp_addr;
word_t exp_wdata;
word_t load_word;

// RV32I integer ops by funct3
function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                  input word_t a, input word_t b);
    case (f3)
        F3_ADD_SUB: return alt ? a - b : a + b;
        F3_SLL:     return a << b[4:0];
        F3_SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        F3_XOR:     return a ^ b;
        F3_SR:      return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
        F3_OR:      return a | b;
        F3_AND:     return a & b;
        default:    return 32'd0;
    endcase
endfunction

// retire one instruction, leaving the expected memory port values behind
function automatic void model_step(input word_t instr);
    logic [2:0] f3;
    word_t      a;
    word_t      b;
    word_t      imm_i;
    word_t      ld_addr;
    word_t      res;
    word_t      next_pc;
    logic       wr;
    f3        = instr[14:12];
    a         = xreg[instr[19:15]];
    b         = xreg[instr[24:20]];
    imm_i     = {{20{instr[31]}}, instr[31:20]};
    ld_addr   = a + imm_i;
    load_word = dmem_model[ld_addr[6:2]];
    wr        = 1'b1;
    res       = '0;
    next_pc   = model_pc + 4;
    exp_we    = 1'b0;
    exp_addr  = a + {{20{instr[31]}}, instr[31:25], instr[11:7]};
    exp_wdata = b;
    case (instr[6:0])
        OPC_OP:     res = alu_ref(f3, instr[30], a, b);
        OPC_OP_IMM: res = alu_ref(f3, instr[30] && f3 == F3_SR, a, imm_i);
        OPC_LUI:    res = {instr[31:12], 12'b0};
        OPC_LOAD:   res = load_word;
        OPC_JAL: begin
            res     = model_pc + 4;
            next_pc = model_pc + {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
        end
        OPC_STORE: begin
            wr     = 1'b0;
            exp_we = 1'b1;
            dmem_model[exp_addr[6:2]] = b;
        end
        default:    wr = 1'b0;
    endcase
    if (wr && instr[11:7] != 5'd0) begin
        xreg[instr[11:7]] = res;
    end
    model_pc = next_pc;
endfunction

// one random instruction from the kept set, now and then an undefined opcode
function automatic word_t gen_instr();
    word_t       r;
    logic [11:0] mem_off;
    logic [11:0] imm;
    logic [20:0] jal_off;
    logic [6:0]  f7;
    logic [2:0]  f3;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    r       = $random(seed);
    rd      = {2'b00, r[6:4]};
    rs1     = {2'b00, r[9:7]};
    rs2     = {2'b00, r[12:10]};
    f3      = (r[15:13] == 3'b011) ? F3_SLT : r[15:13];
    f7      = ((f3 == F3_ADD_SUB || f3 == F3_SR) && r[16]) ? 7'b0100000 : 7'b0;
    // x0 base, word offsets 0 to 124
    mem_off = {5'b0, r[21:17], 2'b00};
    jal_off = {16'b0, r[19:17], 2'b00} + 21'd4;
    case (r[3:0])
        4'd0, 4'd1, 4'd2, 4'd3:
            return {mem_off[11:5], rs2, 5'd0, F3_W, mem_off[4:0], OPC_STORE};
        4'd4, 4'd5, 4'd6, 4'd7:
            return {f7, rs2, rs1, f3, rd, OPC_OP};
        4'd8, 4'd9, 4'd10: begin
            // shifts carry a shamt, srai adds bit 30
            if (f3 == F3_SLL || f3 == F3_SR) begin
                imm = {f7, r[24:20]};
            end else begin
                imm = r[31:20];
            end
            return {imm, rs1, f3, rd, OPC_OP_IMM};
        end
        4'd11:
            return {r[31:12], rd, OPC_LUI};
        4'd12, 4'd13:
            return {mem_off, 5'd0, F3_W, rd, OPC_LOAD};
        4'd14:
            return {jal_off[20], jal_off[10:1], jal_off[11], jal_off[19:12], rd, OPC_JAL};
        default:
            // branch or auipc encodings, outside the kept set
            return {r[31:7], (r[16] ? 7'b1100011 : 7'b0010111)};
    endcase
endfunction

// File: sim/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb
    import rv_pkg::*;
();

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_CYCLES   = 400;
    localparam int PROG_WORDS   = 256;
    localparam int DMEM_WORDS   = 32;

    logic  clk;
    logic  rst_n;
    word_t imem_addr;
    word_t imem_data;
    word_t dmem_addr;
    word_t dmem_wdata;
    logic  dmem_we;
    word_t dmem_rdata;

    integer seed;
    word_t  prog [PROG_WORDS];

    `include "rv_model.svh"

    rv_core UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_rdata (dmem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic compare(input word_t actual, input word_t expected, input string what);
        if (actual !== expected) begin
            $display("Error at time %0t: %s is %h, expected %h", $time, what, actual, expected);
            $display("TEST RESULT: FAIL");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    initial begin
        #((RESET_CYCLES + NUM_CYCLES + 20) * CLK_PERIOD);
        $display("watchdog expired, the run timed out");
        $display("TEST RESULT: FAIL");
        $fatal(1, "timeout");
    end

    initial begin
        seed        = 32'h8f4e;
        rst_n       = 1'b0;
        imem_data   = '0;
        dmem_rdata  = '0;
        model_pc    = '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            xreg[i] = '0;
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem_model[i] = '0;
        end
        for (int i = 0; i < PROG_WORDS; i++) begin
            prog[i] = gen_instr();
        end

        // opcode 0 during reset, so nothing may be stored
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            compare(imem_addr, 32'd0, "imem_addr in reset");
            compare(word_t'(dmem_we), 32'd0, "dmem_we in reset");
        end
        rst_n = 1'b1;

        for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
            compare(imem_addr, model_pc, "imem_addr");
            // program wraps every 256 words
            imem_data = prog[model_pc[9:2]];
            model_step(imem_data);
            dmem_rdata = load_word;
            #(CLK_PERIOD / 5);
            compare(word_t'(dmem_we), word_t'(exp_we), "dmem_we");
            if (exp_we) begin
                compare(dmem_addr, exp_addr, "dmem_addr");
                compare(dmem_wdata, exp_wdata, "dmem_wdata");
            end
            @(negedge clk);
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: hdl/rv_core.sv
`timescale 1ns/1ps

module rv_core
    import rv_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    output word_t imem_addr,
    input  word_t imem_data,
    output word_t dmem_addr,
    output word_t dmem_wdata,
    output logic  dmem_we,
    input  word_t dmem_rdata
);

    decode_t dec;
    word_t   pc;
    word_t   link_addr;
    word_t   rs1_data;
    word_t   rs2_data;
    word_t   alu_result;

    rv_fetch u_fetch (
        .clk       (clk),
        .rst_n     (rst_n),
        .dec       (dec),
        .pc        (pc),
        .link_addr (link_addr)
    );

    rv_decode u_decode (
        .instr (imem_data),
        .dec   (dec)
    );

    rv_execute u_execute (
        .dec        (dec),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .alu_result (alu_result)
    );

    rv_regfile u_regfile (
        .clk        (clk),
        .rst_n      (rst_n),
        .dec        (dec),
        .alu_result (alu_result),
        .load_data  (dmem_rdata),
        .link_addr  (link_addr),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data)
    );

    // memory ports
    assign imem_addr  = pc;
    assign dmem_addr  = alu_result;
    assign dmem_wdata = rs2_data;
    assign dmem_we    = dec.mem_write;

    // no store may leave the core while reset is held
    a_no_store_in_reset: assert property (
        @(posedge clk) !rst_n |-> !dmem_we
    ) else $error("dmem_we high during reset, pc %h", pc);

endmodule

// File: hdl/rv_execute.sv
`timescale 1ns/1ps

module rv_execute
    import rv_pkg::*;
(
    input  decode_t dec,
    input  word_t   rs1_data,
    input  word_t   rs2_data,
    output word_t   alu_result
);

    word_t               op_a;
    word_t               op_b;
    logic [SHAMT_W-1:0]  shamt;
    logic                lt_signed;

    assign op_a = rs1_data;

    // immediate for I-type, lw, sw
    always_comb begin
        if (dec.use_imm) begin
            op_b = dec.imm;
        end else begin
            op_b = rs2_data;
        end
    end

    assign shamt     = op_b[SHAMT_W-1:0];
    assign lt_signed = $signed(op_a) < $signed(op_b);

    always_comb begin
        case (dec.alu_op)
            ADD:     alu_result = op_a + op_b;
            SUB:     alu_result = op_a - op_b;
            AND:     alu_result = op_a & op_b;
            OR:      alu_result = op_a | op_b;
            XOR:     alu_result = op_a ^ op_b;
            SLL:     alu_result = op_a << shamt;
            SRL:     alu_result = op_a >> shamt;
            // sign bit fills from the left
            SRA:     alu_result = word_t'($signed(op_a) >>> shamt);
            SLT:     alu_result = {{(XLEN-1){1'b0}}, lt_signed};
            default: alu_result = op_a + op_b;
        endcase
    end

endmodule

// File: hdl/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile
    import rv_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  decode_t dec,
    input  word_t   alu_result,
    input  word_t   load_data,
    input  word_t   link_addr,
    output word_t   rs1_data,
    output word_t   rs2_data
);

    word_t regs [NUM_REGS];
    word_t wb_data;
    logic  wb_en;

    // write-back mux
    always_comb begin
        case (dec.wb_sel)
            WB_ALU:  wb_data = alu_result;
            WB_LOAD: wb_data = load_data;
            WB_LINK: wb_data = link_addr;
            WB_IMM:  wb_data = dec.imm;
            default: wb_data = alu_result;
        endcase
    end

    // x0 is never written
    assign wb_en = dec.reg_write && (dec.rd != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[dec.rd] <= wb_data;
        end
    end

    // async reads
    assign rs1_data = (dec.rs1 == '0) ? '0 : regs[dec.rs1];
    assign rs2_data = (dec.rs2 == '0) ? '0 : regs[dec.rs2];

    a_x0_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        regs[0] == '0
    ) else $error("x0 holds %h", regs[0]);

endmodule

// File: hdl/rv_decode.sv
`timescale 1ns/1ps

module rv_decode
    import rv_pkg::*;
(
    input  word_t   instr,
    output decode_t dec
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;

    word_t imm_i;
    word_t imm_s;
    word_t imm_u;
    word_t imm_j;
    word_t imm_sh;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    // funct7 bit that selects sub / sra
    assign alt    = instr[30];

    // immediate formats
    assign imm_i  = {{20{instr[31]}}, instr[31:20]};
    assign imm_s  = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_u  = {instr[31:12], 12'b0};
    assign imm_j  = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    assign imm_sh = {{(XLEN-SHAMT_W){1'b0}}, instr[20 +: SHAMT_W]};

    function automatic alu_op_e alu_from_f3(
        input logic [2:0] f3,
        input logic       sub_en,
        input logic       sra_en
    );
        alu_op_e op;
        case (f3)
            F3_ADD_SUB: op = sub_en ? SUB : ADD;
            F3_SLL:     op = SLL;
            F3_SLT:     op = SLT;
            F3_XOR:     op = XOR;
            F3_SR:      op = sra_en ? SRA : SRL;
            F3_OR:      op = OR;
            F3_AND:     op = AND;
            default:    op = ADD;
        endcase
        return op;
    endfunction

    always_comb begin
        dec           = '0;
        dec.rs1       = instr[19:15];
        dec.rs2       = instr[24:20];
        dec.rd        = instr[11:7];
        dec.imm       = imm_i;
        dec.alu_op    = ADD;
        dec.wb_sel    = WB_ALU;

        case (opcode)
            OPC_OP: begin
                dec.alu_op    = alu_from_f3(funct3, alt, alt);
                dec.reg_write = 1'b1;
            end
            OPC_OP_IMM: begin
                // no subtract form for immediates
                dec.alu_op    = alu_from_f3(funct3, 1'b0, alt);
                dec.use_imm   = 1'b1;
                dec.reg_write = 1'b1;
                if (funct3 == F3_SLL || funct3 == F3_SR) begin
                    dec.imm = imm_sh;
                end
            end
            OPC_LUI: begin
                dec.imm       = imm_u;
                dec.wb_sel    = WB_IMM;
                dec.reg_write = 1'b1;
            end
            OPC_LOAD: begin
                dec.use_imm   = 1'b1;
                dec.wb_sel    = WB_LOAD;
                dec.reg_write = (funct3 == F3_W);
            end
            OPC_STORE: begin
                dec.imm       = imm_s;
                dec.use_imm   = 1'b1;
                dec.mem_write = (funct3 == F3_W);
            end
            OPC_JAL: begin
                dec.imm       = imm_j;
                dec.is_jal    = 1'b1;
                dec.wb_sel    = WB_LINK;
                dec.reg_write = 1'b1;
            end
            default: begin
                // anything else retires as a no-op
                dec.reg_write = 1'b0;
                dec.mem_write = 1'b0;
            end
        endcase
    end

    always_comb begin
        a_wr_excl: assert (!(dec.reg_write && dec.mem_write))
            else $error("reg_write and mem_write both set, instr %h", instr);
    end

endmodule

// File: hdl/rv_fetch.sv
`timescale 1ns/1ps

module rv_fetch
    import rv_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  decode_t dec,
    output word_t   pc,
    output word_t   link_addr
);

    word_t jal_target;
    word_t pc_next;

    // sequential successor, also the jal return address
    assign link_addr  = pc + word_t'(4);
    assign jal_target = pc + dec.imm;

    always_comb begin
        if (dec.is_jal) begin
            pc_next = jal_target;
        end else begin
            pc_next = link_addr;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    // jal offsets come from the program, so a bad J-immediate shows up here
    a_pc_aligned: assert property (
        @(posedge clk) disable iff (!rst_n)
        pc[1:0] == 2'b00
    ) else $error("pc not word aligned: %h", pc);

endmodule

// File: hdl/rv_pkg.sv
package rv_pkg;

    // widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int SHAMT_W    = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_idx_t;

    // major opcodes, instr[6:0]
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    // funct3 for OP / OP_IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct3 for word loads and stores
    localparam logic [2:0] F3_W       = 3'b010;

    typedef enum logic [3:0] {
        ADD = 4'd0,
        SUB = 4'd1,
        AND = 4'd2,
        OR  = 4'd3,
        XOR = 4'd4,
        SLL = 4'd5,
        SRL = 4'd6,
        SRA = 4'd7,
        SLT = 4'd8
    } alu_op_e;

    // write-back source
    typedef enum logic [1:0] {
        WB_ALU  = 2'd0,
        WB_LOAD = 2'd1,
        WB_LINK = 2'd2,
        WB_IMM  = 2'd3
    } wb_sel_e;

    // everything the datapath needs from one instruction
    typedef struct packed {
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        word_t    imm;
        alu_op_e  alu_op;
        logic     use_imm;
        logic     reg_write;
        logic     mem_write;
        logic     is_jal;
        wb_sel_e  wb_sel;
    } decode_t;

endpackage
